// File: sources.f
+incdir+.
icache_pkg.sv
l1_fill_if.sv
l0_instruction_cache.sv
l1_line_store.sv
icache_ctrl_regs.sv
fetch_subsystem_top.sv
tb_fetch_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the fetch front end testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f sources.f \
  --top-module tb_fetch_subsystem -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" "$SIM_LOG"; then
  echo "result: PASS"
  exit 0
fi
echo "result: FAIL"
exit 1

// File: tb_fetch_subsystem.sv
/* fetch subsystem testbench */

`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module tb_fetch_subsystem;
  import icache_pkg::*;

  localparam int OFF_BITS   = `ICACHE_OFFSET_BITS;
  localparam int SETS       = `ICACHE_SETS;
  localparam int TAG_LSB    = `ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS;
  localparam int LINE_BITS  = `ICACHE_LINE_BYTES * 8;
  localparam int WAIT_LIMIT = 4 * `L1_LATENCY;  // per fill
  localparam int N_RANDOM   = 100;
  localparam int N_FETCHES  = 29 + N_RANDOM;     // directed plus random
  localparam int N_REG_OPS  = 20;
  localparam int TIMEOUT_CYCLES = 10 + `L1_LINES + 2 + N_FETCHES * (`L1_LATENCY + 4) +
                                  N_REG_OPS * 3 + 50;

  logic        clk = 1'b0;
  logic        reset;
  logic        fetch_valid;
  logic [31:0] pc;
  cache_line_t cache_line;
  logic        line_valid;
  logic        cache_hit;
  logic        reg_write;
  logic [1:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic        mem_write;
  line_addr_t  mem_line_addr;
  cache_line_t mem_line_data;

  cache_line_t ref_lines [`L1_LINES];  // what the store was preloaded with
  logic        model_valid [SETS];     // expected tag state
  logic [31:0] model_tag   [SETS];
  logic        enable_model;
  int          hits_model;
  int          misses_model;
  logic [15:0] lfsr_state = 16'd45;
  int errors, line_errors, prop_errors;  // split by process
  int errors_at_start, tests_run, tests_failed;
  int cycle_count;

  fetch_subsystem_top dut_i (.*);

  always #20 clk = ~clk;  // 40 ns period

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic cache_line_t take_bits(input int n);
    cache_line_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[LINE_BITS-2:0], lfsr_state[15]};  // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // store keeps only the low line address bits
  function automatic int ref_index(input logic [31:0] addr);
    return int'((addr >> OFF_BITS) % `L1_LINES);
  endfunction

  function automatic int total_errors();
    return errors + line_errors + prop_errors;
  endfunction

  // any line shown on the fetch side must match the preload
  always @(negedge clk) begin
    if (!reset && fetch_valid && line_valid) begin
      assert (cache_line == ref_lines[ref_index(pc)]) else begin
        $display("FAIL cache_line pc %h got %h exp %h", pc, cache_line,
                 ref_lines[ref_index(pc)]);
        line_errors++;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) cache_hit |-> line_valid)
    else begin
      $display("cache_hit was high in a cycle without line_valid");
      prop_errors++;
    end

  assert property (@(posedge clk) disable iff (reset) line_valid |-> fetch_valid)
    else begin
      $display("line_valid was high with no fetch in progress");
      prop_errors++;
    end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  task automatic write_reg(input logic [1:0] a, input logic [31:0] d);
    @(posedge clk);
    reg_write <= 1'b1;
    reg_addr  <= a;
    reg_wdata <= d;
    @(posedge clk);
    reg_write <= 1'b0;  // takes effect on this edge
  endtask

  task automatic check_reg(input logic [1:0] a, input logic [31:0] exp, input string name);
    logic [31:0] got;
    @(posedge clk);
    reg_addr <= a;
    @(negedge clk);
    got = reg_rdata;  // combinational read
    assert (got == exp) else begin
      $display("FAIL reg_rdata (%s) got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  // single fetch that waits for the fill on a miss and for the hit after it
  task automatic fetch_line(input logic [31:0] addr, output logic was_hit);
    int   set;
    int   waited;
    logic exp_hit;
    set = int'((addr >> OFF_BITS) % SETS);
    exp_hit = enable_model && model_valid[set] && (model_tag[set] == (addr >> TAG_LSB));
    @(posedge clk);
    fetch_valid <= 1'b1;
    pc          <= addr;
    @(negedge clk);
    was_hit = cache_hit;
    assert (cache_hit === exp_hit) else begin
      $display("FAIL cache_hit pc %h got %h exp %h", addr, cache_hit, exp_hit);
      errors++;
    end
    if (exp_hit) begin
      hits_model++;
    end else begin
      misses_model++;  // store idle, so taken on the next edge
      waited = 0;
      while (line_valid !== 1'b1 && waited <= WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (line_valid !== 1'b1) begin
        $display("no fill arrived for pc %h within %0d cycles", addr, WAIT_LIMIT);
        errors++;
      end else begin
        assert (waited == `L1_LATENCY) else begin
          $display("FAIL fill latency pc %h got %h exp %h", addr, waited, `L1_LATENCY);
          errors++;
        end
        if (enable_model) begin
          model_valid[set] = 1'b1;
          model_tag[set]   = addr >> TAG_LSB;
          @(negedge clk);  // written at the end of the fill cycle
          assert (cache_hit === 1'b1) else begin
            $display("FAIL cache_hit after fill pc %h got %h exp 1", addr, cache_hit);
            errors++;
          end
          hits_model++;
        end
      end
    end
    @(posedge clk);
    fetch_valid <= 1'b0;
  endtask

  task automatic flush_cache();
    write_reg(2'd0, 32'h3);  // keep enable and pulse flush
    for (int s = 0; s < SETS; s++) begin
      model_valid[s] = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (total_errors() == errors_at_start) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name,
               total_errors() - errors_at_start);
    end
    errors_at_start = total_errors();
  endtask

  initial begin
    logic        hit;
    cache_line_t rnd;
    reset         = 1'b1;
    fetch_valid   = 1'b0;
    pc            = '0;
    reg_write     = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    mem_write     = 1'b0;
    mem_line_addr = '0;
    mem_line_data = '0;
    enable_model  = 1'b1;
    for (int s = 0; s < SETS; s++) begin
      model_valid[s] = 1'b0;
      model_tag[s]   = '0;
    end
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < `L1_LINES; i++) begin  // preload every store line
      ref_lines[i] = take_bits(LINE_BITS);
      @(posedge clk);
      mem_write     <= 1'b1;
      mem_line_addr <= line_addr_t'(i);
      mem_line_data <= ref_lines[i];
    end
    @(posedge clk);
    mem_write <= 1'b0;

    fetch_line(32'h0000_1000, hit);
    assert (!hit) else begin
      $display("first fetch after preload hit in an empty cache");
      errors++;
    end
    fetch_line(32'h0000_1004, hit);  // same line at another offset
    finish_test("miss fill hit");

    fetch_line(32'h0000_0080, hit);  // set 2 stays put
    fetch_line(32'h0000_0040, hit);  // set 1 tag 0
    fetch_line(32'h0000_0240, hit);  // set 1 tag 1 evicts it
    fetch_line(32'h0000_0040, hit);
    assert (!hit) else begin
      $display("evicted line at pc 00000040 still hit");
      errors++;
    end
    fetch_line(32'h0000_0080, hit);
    assert (hit) else begin
      $display("line in an untouched set was lost by the eviction");
      errors++;
    end
    finish_test("conflict eviction");

    for (int s = 0; s < SETS; s++) begin
      fetch_line(32'(s * 64), hit);
    end
    flush_cache();
    check_reg(2'd0, 32'h1, "control after flush");  // flush bit reads 0
    for (int s = 0; s < SETS; s++) begin
      fetch_line(32'(s * 64), hit);
      assert (!hit) else begin
        $display("pc %h hit after a flush", s * 64);
        errors++;
      end
    end
    finish_test("flush");

    write_reg(2'd0, 32'h0);
    enable_model = 1'b0;
    check_reg(2'd0, 32'h0, "control");
    repeat (3) begin
      fetch_line(32'h0000_0080, hit);  // cached but must not hit
      assert (!hit) else begin
        $display("fetch hit while the cache was disabled");
        errors++;
      end
    end
    write_reg(2'd0, 32'h1);
    enable_model = 1'b1;
    fetch_line(32'h0000_0080, hit);  // tags survived the disable
    finish_test("disable");

    check_reg(2'd1, hits_model, "hit count");
    check_reg(2'd2, misses_model, "miss count");
    write_reg(2'd1, 32'h1234_5678);
    write_reg(2'd2, 32'hffff_ffff);
    hits_model   = 0;
    misses_model = 0;
    check_reg(2'd1, 32'h0, "hit count after clear");
    check_reg(2'd2, 32'h0, "miss count after clear");
    check_reg(2'd3, 32'h0, "unused address");
    fetch_line(32'h0000_0080, hit);
    fetch_line(32'h0000_0400, hit);  // set 0 with a new tag
    check_reg(2'd1, hits_model, "hit count");
    check_reg(2'd2, misses_model, "miss count");
    finish_test("counters");

    for (int n = 0; n < N_RANDOM; n++) begin
      rnd = take_bits(OFF_BITS + $clog2(`L1_LINES));  // covers every store line
      fetch_line(rnd[31:0], hit);
    end
    finish_test("random fetch stream");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fetch_subsystem_top.sv
/* instruction fetch front end */

`timescale 1ns/10ps
`default_nettype none

module fetch_subsystem_top (
  input  wire logic                    clk,
  input  wire logic                    reset,
  // fetch side
  input  wire logic                    fetch_valid,
  input  wire icache_pkg::fetch_addr_u pc,
  output icache_pkg::cache_line_t      cache_line,
  output logic                         line_valid,
  output logic                         cache_hit,
  // register bus
  input  wire logic                    reg_write,
  input  wire logic [1:0]              reg_addr,
  input  wire logic [31:0]             reg_wdata,
  output logic      [31:0]             reg_rdata,
  // l1 preload
  input  wire logic                    mem_write,
  input  wire icache_pkg::line_addr_t  mem_line_addr,
  input  wire icache_pkg::cache_line_t mem_line_data
);

  logic enable;
  logic flush_pulse;
  logic hit_event;
  logic miss_event;

  l1_fill_if l1_bus ();  // miss and fill traffic

  l0_instruction_cache l0_i (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .pc          (pc),
    .enable      (enable),
    .flush_pulse (flush_pulse),
    .cache_line  (cache_line),
    .cache_hit   (cache_hit),
    .line_valid  (line_valid),
    .hit_event   (hit_event),
    .miss_event  (miss_event),
    .l1          (l1_bus.cache)
  );

  l1_line_store l1_i (
    .clk           (clk),
    .reset         (reset),
    .mem_write     (mem_write),
    .mem_line_addr (mem_line_addr),
    .mem_line_data (mem_line_data),
    .l1            (l1_bus.store)
  );

  icache_ctrl_regs regs_i (
    .clk         (clk),
    .reset       (reset),
    .reg_write   (reg_write),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .hit_event   (hit_event),
    .miss_event  (miss_event),
    .reg_rdata   (reg_rdata),
    .enable      (enable),
    .flush_pulse (flush_pulse)
  );

endmodule

`default_nettype wire

// File: icache_ctrl_regs.sv
/* icache control registers */

`timescale 1ns/10ps
`default_nettype none

module icache_ctrl_regs (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        reg_write,
  input  wire logic [1:0]  reg_addr,
  input  wire logic [31:0] reg_wdata,
  input  wire logic        hit_event,   // one per hit cycle
  input  wire logic        miss_event,  // one per accepted l1 request
  output logic      [31:0] reg_rdata,
  output logic             enable,
  output logic             flush_pulse
);

  localparam logic [1:0] ADDR_CTRL = 2'd0;
  localparam logic [1:0] ADDR_HITS = 2'd1;
  localparam logic [1:0] ADDR_MISS = 2'd2;

  logic [31:0] hit_count;
  logic [31:0] miss_count;

  always_ff @(posedge clk) begin
    if (reset) begin
      enable      <= 1'b1;  // cache on out of reset
      flush_pulse <= 1'b0;
    end else begin
      // flush bit never sticks, one cycle only
      flush_pulse <= reg_write && (reg_addr == ADDR_CTRL) && reg_wdata[1];
      if (reg_write && (reg_addr == ADDR_CTRL)) begin
        enable <= reg_wdata[0];
      end
    end
  end

  // any write clears a counter, otherwise count events
  always_ff @(posedge clk) begin
    if (reset) begin
      hit_count  <= '0;
      miss_count <= '0;
    end else begin
      if (reg_write && (reg_addr == ADDR_HITS)) begin
        hit_count <= '0;
      end else if (hit_event) begin
        hit_count <= hit_count + 1'b1;
      end
      if (reg_write && (reg_addr == ADDR_MISS)) begin
        miss_count <= '0;
      end else if (miss_event) begin
        miss_count <= miss_count + 1'b1;
      end
    end
  end

  // read mux
  always_comb begin
    case (reg_addr)
      ADDR_CTRL: reg_rdata = {30'd0, 1'b0, enable};  // flush reads 0
      ADDR_HITS: reg_rdata = hit_count;
      ADDR_MISS: reg_rdata = miss_count;
      default:   reg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: l1_line_store.sv
/* L1 line store model */

`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module l1_line_store (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   mem_write,      // preload strobe
  input  wire icache_pkg::line_addr_t mem_line_addr,
  input  wire icache_pkg::cache_line_t mem_line_data,
  l1_fill_if.store                    l1
);
  import icache_pkg::*;

  localparam int LINE_IDX_BITS = $clog2(`L1_LINES);
  // counter starts at latency-2, fill register adds the last cycle
  localparam int CNT_BITS      = (`L1_LATENCY > 2) ? $clog2(`L1_LATENCY) : 1;

  cache_line_t mem [`L1_LINES];

  logic                     busy;          // request taken, fill pending
  logic [CNT_BITS-1:0]      count;
  logic [LINE_IDX_BITS-1:0] rd_idx;        // line of the current request
  logic                     fill_valid_q;
  cache_line_t              fill_data_q;
  logic                     take_req;
  logic                     fire;          // last wait cycle

  assign take_req = !busy && l1.req;
  assign fire     = busy && (count == '0);

  assign l1.l1_ready   = !busy;
  assign l1.fill_valid = fill_valid_q;
  assign l1.fill_data  = fill_data_q;

  // preload, only low line address bits select the entry
  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[mem_line_addr[LINE_IDX_BITS-1:0]] <= mem_line_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy         <= 1'b0;
      count        <= '0;
      fill_valid_q <= 1'b0;
    end else begin
      fill_valid_q <= 1'b0;  // pulse
      if (take_req) begin
        busy  <= 1'b1;
        count <= CNT_BITS'(`L1_LATENCY - 2);
      end else if (fire) begin
        busy         <= 1'b0;  // ready again in the fill cycle
        fill_valid_q <= 1'b1;
      end else if (busy) begin
        count <= count - 1'b1;
      end
    end
  end

  // payload side
  always_ff @(posedge clk) begin
    if (take_req) begin
      rd_idx <= l1.req_addr[LINE_IDX_BITS-1:0];
    end
    if (fire) begin
      fill_data_q <= mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

// File: l0_instruction_cache.sv
/* L0 instruction cache, direct mapped */

`timescale 1ns/10ps
`default_nettype none

`include "icache_macros.svh"

module l0_instruction_cache (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    fetch_valid,  // pc is a real fetch
  input  wire icache_pkg::fetch_addr_u pc,
  input  wire logic                    enable,       // low: bypass, no hits, no allocate
  input  wire logic                    flush_pulse,  // drop every tag
  output icache_pkg::cache_line_t      cache_line,
  output logic                         cache_hit,
  output logic                         line_valid,   // cache_line usable this cycle
  output logic                         hit_event,
  output logic                         miss_event,
  l1_fill_if.cache                     l1
);
  import icache_pkg::*;

  localparam int SETS     = `ICACHE_SETS;
  localparam int OFF_BITS = `ICACHE_OFFSET_BITS;

  tag_entry_t  tag_array  [SETS];
  cache_line_t data_array [SETS];

  logic        req_held;       // raised while l1 was busy, not yet taken
  logic        pend_valid;     // taken by l1, fill still to come
  line_addr_t  pend_addr;      // line of the held or pending request
  fetch_addr_u fill_pc;        // pend_addr seen as a pc for set and tag
  line_addr_t  cur_line_addr;
  logic        lookup_hit;
  logic        fill_match;     // fill belongs to the line being fetched
  logic        fill_write;
  logic        accept;

  assign cur_line_addr = {pc.fields.tag, pc.fields.index};

  always_comb begin
    fill_pc.raw = {pend_addr, {OFF_BITS{1'b0}}};
  end

  // tag compare at pc's set
  assign lookup_hit = tag_array[pc.fields.index].valid &&
                      (tag_array[pc.fields.index].tag == pc.fields.tag);
  assign cache_hit  = fetch_valid && enable && lookup_hit;  // disable hides hits

  assign fill_match = l1.fill_valid && pend_valid && (pend_addr == cur_line_addr);
  assign line_valid = cache_hit || (fetch_valid && fill_match);

  // fill data is forwarded straight through in the fill cycle
  always_comb begin
    if (fill_match) begin
      cache_line = l1.fill_data;
    end else if (cache_hit) begin
      cache_line = data_array[pc.fields.index];
    end else begin
      cache_line = '0;
    end
  end

  // one request in flight at most
  assign l1.req      = req_held || (fetch_valid && !cache_hit && !pend_valid);
  assign l1.req_addr = req_held ? pend_addr : cur_line_addr;  // held address stays put
  assign accept      = l1.req && l1.l1_ready;

  assign hit_event  = cache_hit;
  assign miss_event = accept;  // counted once per accepted request

  assign fill_write = l1.fill_valid && pend_valid && enable;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_held   <= 1'b0;
      pend_valid <= 1'b0;
    end else begin
      if (accept) begin
        req_held   <= 1'b0;
        pend_valid <= 1'b1;
      end else if (l1.req) begin
        req_held <= 1'b1;  // store busy, keep asking for the same line
      end
      if (l1.fill_valid) begin
        pend_valid <= 1'b0;
      end
    end
  end

  // request address, captured whenever a request is up
  always_ff @(posedge clk) begin
    if (l1.req) begin
      pend_addr <= l1.req_addr;
    end
  end

  // tags; flush wins over a fill landing on the same edge
  always_ff @(posedge clk) begin
    if (reset || flush_pulse) begin
      for (int s = 0; s < SETS; s++) begin
        tag_array[s] <= '0;
      end
    end else if (fill_write) begin
      tag_array[fill_pc.fields.index] <= '{valid: 1'b1, tag: fill_pc.fields.tag};
    end
  end

  always_ff @(posedge clk) begin
    if (fill_write) begin
      data_array[fill_pc.fields.index] <= l1.fill_data;  // requested set, not pc's set
    end
  end

endmodule

`default_nettype wire

// File: l1_fill_if.sv
/* l0 to l1 fill bus */

`timescale 1ns/10ps
`default_nettype none

interface l1_fill_if;
  import icache_pkg::*;

  logic        req;         // miss request, held as a level
  line_addr_t  req_addr;    // line the cache wants
  logic        l1_ready;    // store idle, takes req on this edge
  logic        fill_valid;  // single cycle
  cache_line_t fill_data;   // only meaningful with fill_valid

  // cache side asks and receives
  modport cache (
    output req, req_addr,
    input  l1_ready, fill_valid, fill_data
  );

  // store side answers
  modport store (
    input  req, req_addr,
    output l1_ready, fill_valid, fill_data
  );

endinterface

`default_nettype wire

// File: icache_pkg.sv
/* icache types */

`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

  // one full instruction line
  typedef logic [`ICACHE_LINE_BYTES*8-1:0] cache_line_t;

  // pc split for lookup, msb first
  typedef struct packed {
    logic [`ICACHE_TAG_BITS-1:0]    tag;
    logic [`ICACHE_INDEX_BITS-1:0]  index;
    logic [`ICACHE_OFFSET_BITS-1:0] offset;  // byte within line
  } fetch_addr_fields_t;

  // same word seen as a raw pc or as its fields
  typedef union packed {
    logic [`ICACHE_PC_BITS-1:0] raw;
    fetch_addr_fields_t         fields;
  } fetch_addr_u;

  typedef struct packed {
    logic                        valid;
    logic [`ICACHE_TAG_BITS-1:0] tag;
  } tag_entry_t;

  // pc without the offset bits, what l1 is addressed with
  typedef logic [`ICACHE_PC_BITS-`ICACHE_OFFSET_BITS-1:0] line_addr_t;

endpackage

`default_nettype wire

// File: icache_macros.svh
/* icache geometry and l1 timing */

`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// l0 geometry, sets must stay a power of two
`define ICACHE_SETS        8
`define ICACHE_LINE_BYTES  64
`define ICACHE_PC_BITS     32

// derived field widths of a fetch pc
`define ICACHE_OFFSET_BITS $clog2(`ICACHE_LINE_BYTES)
`define ICACHE_INDEX_BITS  $clog2(`ICACHE_SETS)
`define ICACHE_TAG_BITS    (`ICACHE_PC_BITS - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)

// backing store
`define L1_LINES           64
`define L1_LATENCY         3   // acceptance edge to fill pulse, 2 or more

`endif
